// ==== aluVectors.txt ====
// columns: aluOp aluSrc fwdA fwdB rd1 rd2 imm pc resultW aluResultM
// then expected: result branchTaken pcTarget
04 1 0 0 15 99 fffffffffffffff0 0 0 0 5 0 0
05 0 1 2 1 2 0 0 3 5 fffffffffffffffe 0 0
0e 0 2 1 1 2 0 0 ff0 ff00 f0f0 0 0
0f 1 0 0 f00 0 f 0 0 0 f0f 0 0
10 0 3 3 ffffffffffffffff 1234 0 0 5 6 1234 0 0
11 0 0 0 ffffffffffffffff 1 0 0 0 0 1 0 0
12 0 0 0 ffffffffffffffff 1 0 0 0 0 0 0 0
01 0 0 0 1 3f 0 0 0 0 8000000000000000 0 0
02 0 0 0 8000000000000000 3c 0 0 0 0 8 0 0
03 0 0 0 8000000000000000 4 0 0 0 0 f800000000000000 0 0
24 0 0 0 7fffffff 1 0 0 0 0 ffffffff80000000 0 0
25 0 0 0 1 2 0 0 0 0 ffffffffffffffff 0 0
21 0 0 0 1 3f 0 0 0 0 ffffffff80000000 0 0
22 0 0 0 ffffffff80000000 4 0 0 0 0 8000000 0 0
23 0 0 0 80000000 4 0 0 0 0 fffffffff8000000 0 0
14 1 0 0 5 0 12345000 0 0 0 12345000 0 0
13 1 0 0 7 0 2000 1000 0 0 3000 0 0
16 1 0 0 0 0 40 1000 0 0 1004 1 1040
15 1 2 0 5 0 8 2000 0 3000 2004 1 3008
17 0 0 0 a a 10 100 0 0 0 1 110
18 0 0 0 a a fffffffffffffff0 100 0 0 0 0 f0
19 0 0 0 ffffffffffffffff 1 20 200 0 0 0 1 220
1a 0 0 0 ffffffffffffffff 1 20 200 0 0 0 0 220
1b 0 0 0 1 ffffffffffffffff 8 300 0 0 0 1 308
1c 0 0 0 1 ffffffffffffffff 8 300 0 0 0 0 308

// ==== sources.f ====
rvIsaPkg.sv
execPkg.sv
operandSelect.sv
issueQueue.sv
aluExecute.sv
execUnit.sv
tbExecUnit.sv

// ==== runSim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbExecUnit -f sources.f -o simExec > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simExec > sim.log 2>&1 ; cat sim.log
grep -qx "Verification passed" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== tbExecUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbExecUnit;
  import rvIsaPkg::*;
  import execPkg::*;

  localparam int numVectors = 25;
  localparam int fieldsPerVector = 13; // 10 stimulus and 3 expected
  localparam int memDepth = 512;
  localparam int addrWidth = $clog2(memDepth);
  localparam int maxCycles = 20 * numVectors + 50;

  logic clk;
  logic arstN;
  logic inValid;
  logic inReady;
  logic [aluOpWidth-1:0] aluOp;
  logic aluSrc;
  logic [fwdSelWidth-1:0] fwdA;
  logic [fwdSelWidth-1:0] fwdB;
  logic [xlen-1:0] rd1;
  logic [xlen-1:0] rd2;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] resultW;
  logic [xlen-1:0] aluResultM;
  logic outValid;
  logic outReady;
  logic [xlen-1:0] result;
  logic branchTaken;
  logic [xlen-1:0] pcTarget;

  logic [xlen-1:0] vecMem [memDepth];
  logic [xlen-1:0] expResultQ [$];
  logic [xlen-1:0] expTakenQ [$];
  logic [xlen-1:0] expTargetQ [$];
  int testIdxQ [$];
  int errorCount;
  int doneCount;
  int cycleCount;

  execUnit dut0 (
    .clk(clk),
    .arstN(arstN),
    .inValid(inValid),
    .inReady(inReady),
    .aluOp(aluOp),
    .aluSrc(aluSrc),
    .fwdA(fwdA),
    .fwdB(fwdB),
    .rd1(rd1),
    .rd2(rd2),
    .imm(imm),
    .pc(pc),
    .resultW(resultW),
    .aluResultM(aluResultM),
    .outValid(outValid),
    .outReady(outReady),
    .result(result),
    .branchTaken(branchTaken),
    .pcTarget(pcTarget)
  );

  function automatic logic [xlen-1:0] field(input int vec, input int col);
    return vecMem[addrWidth'(vec * fieldsPerVector + col)];
  endfunction

  task automatic applyVector(input int vec);
    aluOp = aluOpWidth'(field(vec, 0));
    aluSrc = 1'(field(vec, 1));
    fwdA = fwdSelWidth'(field(vec, 2));
    fwdB = fwdSelWidth'(field(vec, 3));
    rd1 = field(vec, 4);
    rd2 = field(vec, 5);
    imm = field(vec, 6);
    pc = field(vec, 7);
    resultW = field(vec, 8); // held with the operation until accepted
    aluResultM = field(vec, 9);
    inValid = 1'b1;
    expResultQ.push_back(field(vec, 10));
    expTakenQ.push_back(field(vec, 11));
    expTargetQ.push_back(field(vec, 12));
    testIdxQ.push_back(vec);
  endtask

  // inReady checked mid-cycle before the transfer edge
  task automatic waitAccept();
    @(negedge clk);
    while (!inReady) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic checkValue(input string what, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic scoreOutput();
    int vec;
    int errorsBefore;
    if (testIdxQ.size() == 0) begin
      errorCount++;
      $display("An output arrived at %0t ns while no test was waiting for one", $time);
    end else begin
      vec = testIdxQ.pop_front();
      errorsBefore = errorCount;
      checkValue("result", result, expResultQ.pop_front());
      checkValue("branchTaken", xlen'(branchTaken), expTakenQ.pop_front());
      checkValue("pcTarget", pcTarget, expTargetQ.pop_front());
      doneCount++;
      $display("test %0d op %h: %s", vec, aluOpWidth'(field(vec, 0)),
               (errorCount == errorsBefore) ? "ok" : "mismatch");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // random output stalls
  initial begin
    outReady = 1'b0;
    void'($urandom(32'hd08a8ccd));
    forever begin
      @(posedge clk);
      #1 outReady = ($urandom % 3) != 0; // low on about a third of cycles
    end
  end

  // output transfers checked mid-cycle where outputs are stable
  initial begin
    forever begin
      @(negedge clk);
      if (arstN && outValid && outReady) begin
        scoreOutput();
      end
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < maxCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: only %0d of %0d tests finished after %0d cycles",
             doneCount, numVectors, maxCycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    arstN = 1'b0;
    inValid = 1'b0;
    aluOp = '0;
    aluSrc = 1'b0;
    fwdA = '0;
    fwdB = '0;
    rd1 = '0;
    rd2 = '0;
    imm = '0;
    pc = '0;
    resultW = '0;
    aluResultM = '0;
    errorCount = 0;
    doneCount = 0;
    $readmemh("aluVectors.txt", vecMem);
    repeat (2) @(posedge clk);
    #1 arstN = 1'b1;
    for (int i = 0; i < numVectors; i++) begin
      applyVector(i);
      waitAccept();
    end
    inValid = 1'b0;
    wait (doneCount == numVectors);
    repeat (4) @(posedge clk); // catch any extra output
    $display("tests %0d, checked %0d, errors %0d", numVectors, doneCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== execUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module execUnit (
  input  logic clk,
  input  logic arstN,
  input  logic inValid,
  output logic inReady,
  input  logic [rvIsaPkg::aluOpWidth-1:0] aluOp,
  input  logic aluSrc,
  input  logic [execPkg::fwdSelWidth-1:0] fwdA,
  input  logic [execPkg::fwdSelWidth-1:0] fwdB,
  input  logic [rvIsaPkg::xlen-1:0] rd1,
  input  logic [rvIsaPkg::xlen-1:0] rd2,
  input  logic [rvIsaPkg::xlen-1:0] imm,
  input  logic [rvIsaPkg::xlen-1:0] pc,
  input  logic [rvIsaPkg::xlen-1:0] resultW,
  input  logic [rvIsaPkg::xlen-1:0] aluResultM,
  output logic outValid,
  input  logic outReady,
  output logic [rvIsaPkg::xlen-1:0] result,
  output logic branchTaken,
  output logic [rvIsaPkg::xlen-1:0] pcTarget
);
  import execPkg::*;

  logic issueValid;
  logic issueReady;
  issueBundle issueData;
  logic execValid;
  logic execReady;
  issueBundle execData;

  operandSelect select0 (
    .clk(clk),
    .arstN(arstN),
    .inValid(inValid),
    .inReady(inReady),
    .aluOp(aluOp),
    .aluSrc(aluSrc),
    .fwdA(fwdA),
    .fwdB(fwdB),
    .rd1(rd1),
    .rd2(rd2),
    .imm(imm),
    .pc(pc),
    .resultW(resultW),
    .aluResultM(aluResultM),
    .issueValid(issueValid),
    .issueReady(issueReady),
    .issueData(issueData)
  );

  issueQueue #(.payloadT(issueBundle)) queue0 ( // decouples producer stalls
    .clk(clk),
    .arstN(arstN),
    .pushValid(issueValid),
    .pushReady(issueReady),
    .pushData(issueData),
    .popValid(execValid),
    .popReady(execReady),
    .popData(execData)
  );

  aluExecute alu0 (
    .clk(clk),
    .arstN(arstN),
    .execValid(execValid),
    .execReady(execReady),
    .execData(execData),
    .outValid(outValid),
    .outReady(outReady),
    .result(result),
    .pcTarget(pcTarget),
    .branchTaken(branchTaken)
  );

endmodule

`default_nettype wire

// ==== aluExecute.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluExecute (
  input  logic clk,
  input  logic arstN,
  input  logic execValid,
  output logic execReady,
  input  execPkg::issueBundle execData,
  output logic outValid,
  input  logic outReady,
  output logic [rvIsaPkg::xlen-1:0] result,
  output logic [rvIsaPkg::xlen-1:0] pcTarget,
  output logic branchTaken
);
  import rvIsaPkg::*;

  logic [opWordFlag-1:0] op;
  logic [xlen-1:0] srcA;
  logic [xlen-1:0] srcB;
  logic [wordWidth-1:0] wordRes;
  logic [xlen-1:0] resultNext;
  logic [xlen-1:0] targetNext;
  logic takenNext;
  logic isJump;
  logic load;

  assign op = execData.aluOp[opWordFlag-1:0];
  assign srcA = execData.srcA;
  assign srcB = execData.srcB;
  assign isJump = execData.jumpBase || (op == opJal);

  // word forms, low half with 5-bit shift amount
  always_comb begin
    case (op)
      opSll: wordRes = srcA[wordWidth-1:0] << srcB[wordShamtWidth-1:0];
      opSrl: wordRes = srcA[wordWidth-1:0] >> srcB[wordShamtWidth-1:0];
      opSra: wordRes = $signed(srcA[wordWidth-1:0]) >>> srcB[wordShamtWidth-1:0];
      opAdd: wordRes = srcA[wordWidth-1:0] + srcB[wordWidth-1:0];
      opSub: wordRes = srcA[wordWidth-1:0] - srcB[wordWidth-1:0];
      default: wordRes = '0;
    endcase
  end

  always_comb begin
    resultNext = '0;
    takenNext = 1'b0;
    targetNext = '0;
    if (execData.aluOp[opWordFlag]) begin
      resultNext = {{(xlen-wordWidth){wordRes[wordWidth-1]}}, wordRes};
    end else if (isJump) begin
      resultNext = execData.pcLink; // jal/jalr write the return address
      takenNext = 1'b1;
      targetNext = execData.pc;
    end else begin
      case (op)
        opSll: resultNext = srcA << srcB[shamtWidth-1:0];
        opSrl: resultNext = srcA >> srcB[shamtWidth-1:0];
        opSra: resultNext = $signed(srcA) >>> srcB[shamtWidth-1:0];
        opAdd: resultNext = srcA + srcB;
        opSub: resultNext = srcA - srcB;
        opXor: resultNext = srcA ^ srcB;
        opOr: resultNext = srcA | srcB;
        opAnd: resultNext = srcA & srcB;
        opSlt: resultNext = xlen'($signed(srcA) < $signed(srcB));
        opSltu: resultNext = xlen'(srcA < srcB);
        opAuipc: resultNext = srcA + srcB; // srcA already holds pc
        opLui: resultNext = srcB;
        opBeq: takenNext = srcA == srcB;
        opBne: takenNext = srcA != srcB;
        opBlt: takenNext = $signed(srcA) < $signed(srcB);
        opBge: takenNext = $signed(srcA) >= $signed(srcB);
        opBltu: takenNext = srcA < srcB;
        opBgeu: takenNext = srcA >= srcB;
        default: resultNext = '0;
      endcase
      if (op inside {[opBeq:opBgeu]}) begin
        targetNext = execData.pc; // pc + imm from the producer
      end
    end
  end

  assign execReady = !outValid || outReady;
  assign load = execValid && execReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      result <= '0;
      pcTarget <= '0;
      branchTaken <= 1'b0;
    end else begin
      if (load) begin
        outValid <= 1'b1;
        result <= resultNext;
        pcTarget <= targetNext;
        branchTaken <= takenNext;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== issueQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module issueQueue #(
  parameter type payloadT = logic
) (
  input  logic clk,
  input  logic arstN,
  input  logic pushValid,
  output logic pushReady,
  input  payloadT pushData,
  output logic popValid,
  input  logic popReady,
  output payloadT popData
);
  import execPkg::*;

  payloadT entries [queueDepth];
  logic [$clog2(queueDepth)-1:0] wrPtr;
  logic [$clog2(queueDepth)-1:0] rdPtr;
  logic [$clog2(queueDepth+1)-1:0] count;
  logic doPush;
  logic doPop;

  function automatic logic [$clog2(queueDepth)-1:0] nextPtr(
    input logic [$clog2(queueDepth)-1:0] ptr
  );
    return (ptr == queueDepth - 1) ? '0 : ptr + 1'b1; // circular
  endfunction

  assign pushReady = count < queueDepth;
  assign popValid = count != '0;
  assign popData = entries[rdPtr]; // head entry, registered store
  assign doPush = pushValid && pushReady;
  assign doPop = popValid && popReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      for (int i = 0; i < queueDepth; i++) begin
        entries[i] <= '0;
      end
    end else begin
      if (doPush) begin
        entries[wrPtr] <= pushData;
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== operandSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

module operandSelect (
  input  logic clk,
  input  logic arstN,
  input  logic inValid,
  output logic inReady,
  input  logic [rvIsaPkg::aluOpWidth-1:0] aluOp,
  input  logic aluSrc,
  input  logic [execPkg::fwdSelWidth-1:0] fwdA,
  input  logic [execPkg::fwdSelWidth-1:0] fwdB,
  input  logic [rvIsaPkg::xlen-1:0] rd1,
  input  logic [rvIsaPkg::xlen-1:0] rd2,
  input  logic [rvIsaPkg::xlen-1:0] imm,
  input  logic [rvIsaPkg::xlen-1:0] pc,
  input  logic [rvIsaPkg::xlen-1:0] resultW,
  input  logic [rvIsaPkg::xlen-1:0] aluResultM,
  output logic issueValid,
  input  logic issueReady,
  output execPkg::issueBundle issueData
);
  import rvIsaPkg::*;
  import execPkg::*;

  logic [xlen-1:0] fwdValA;
  logic [xlen-1:0] fwdValB;
  logic [xlen-1:0] targetBase;
  logic isJalr;
  logic accept;
  issueBundle issueNext;

  function automatic logic [xlen-1:0] pickSource(
    input logic [fwdSelWidth-1:0] sel,
    input logic [xlen-1:0] regVal,
    input logic [xlen-1:0] wbVal,
    input logic [xlen-1:0] memVal
  );
    case (sel)
      fwdReg: return regVal;
      fwdWriteback: return wbVal;
      fwdMemory: return memVal;
      default: return regVal; // unused code reads the register file
    endcase
  endfunction

  assign fwdValA = pickSource(fwdA, rd1, resultW, aluResultM);
  assign fwdValB = pickSource(fwdB, rd2, resultW, aluResultM);
  assign isJalr = (aluOp[opWordFlag-1:0] == opJalr) && !aluOp[opWordFlag];
  assign targetBase = isJalr ? fwdValA : pc;

  always_comb begin
    issueNext.aluOp = aluOp;
    issueNext.srcA = (aluOp[opWordFlag-1:0] == opAuipc) ? pc : fwdValA;
    issueNext.srcB = aluSrc ? imm : fwdValB; // branches keep the compare operand
    issueNext.pc = targetBase + imm; // one adder for jal, jalr and branches
    issueNext.pcLink = pc + xlen'(instrBytes);
    issueNext.jumpBase = isJalr;
  end

  assign inReady = !issueValid || issueReady; // empty or draining now
  assign accept = inValid && inReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      issueValid <= 1'b0;
      issueData <= '0;
    end else begin
      if (accept) begin
        issueValid <= 1'b1;
        issueData <= issueNext;
      end else if (issueReady) begin
        issueValid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== execPkg.sv ====
`default_nettype none

package execPkg;

  localparam int fwdSelWidth = 2;

  // forward select, code 3 decodes like fwdReg
  localparam logic [fwdSelWidth-1:0] fwdReg = 2'd0;
  localparam logic [fwdSelWidth-1:0] fwdWriteback = 2'd1;
  localparam logic [fwdSelWidth-1:0] fwdMemory = 2'd2;

  localparam int queueDepth = 2;

  // one resolved operation on its way to the ALU
  typedef struct packed {
    logic [rvIsaPkg::aluOpWidth-1:0] aluOp;
    logic [rvIsaPkg::xlen-1:0] srcA; // forwarded A, pc for auipc
    logic [rvIsaPkg::xlen-1:0] srcB; // imm or forwarded B
    logic [rvIsaPkg::xlen-1:0] pc; // jump/branch target, base + imm
    logic [rvIsaPkg::xlen-1:0] pcLink; // return address
    logic jumpBase; // target based on rs1, jalr only
  } issueBundle;

endpackage

`default_nettype wire

// ==== rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

  localparam int xlen = 64;
  localparam int wordWidth = 32; // word forms work on the low half
  localparam int shamtWidth = $clog2(xlen);
  localparam int wordShamtWidth = $clog2(wordWidth);

  localparam int aluOpWidth = 6; // {word flag, operation}
  localparam int opWordFlag = 5;
  localparam int instrBytes = 4; // link offset for jal/jalr

  // operation codes in aluOp[4:0]
  localparam logic [4:0] opSll = 5'd1;
  localparam logic [4:0] opSrl = 5'd2;
  localparam logic [4:0] opSra = 5'd3;
  localparam logic [4:0] opAdd = 5'd4; // also load/store address
  localparam logic [4:0] opSub = 5'd5;

  // 6..13 were mul/div/rem, not handled in this lane
  localparam logic [4:0] opXor = 5'd14;
  localparam logic [4:0] opOr = 5'd15;
  localparam logic [4:0] opAnd = 5'd16;
  localparam logic [4:0] opSlt = 5'd17;
  localparam logic [4:0] opSltu = 5'd18;
  localparam logic [4:0] opAuipc = 5'd19;
  localparam logic [4:0] opLui = 5'd20;

  localparam logic [4:0] opJalr = 5'd21; // jumps and branches from here up
  localparam logic [4:0] opJal = 5'd22;
  localparam logic [4:0] opBeq = 5'd23;
  localparam logic [4:0] opBne = 5'd24;
  localparam logic [4:0] opBlt = 5'd25;
  localparam logic [4:0] opBge = 5'd26;
  localparam logic [4:0] opBltu = 5'd27;
  localparam logic [4:0] opBgeu = 5'd28;

endpackage

`default_nettype wire
